/* rtl/rvdec_pkg.sv */
/*
 * Shared types of the RV32 decode stage
 * illegal_insn must remain the first (MSB) field of decoder_ctrl_t
 * No CSR, B-extension or debug encodings are defined here
 */
`default_nettype none

package rvdec_pkg;

  ////////////////////////////////////////
  // Core configuration
  ////////////////////////////////////////
  typedef enum logic       {RV32I, RV32E} rv32_e;              // Register file flavour
  typedef enum logic [1:0] {M_NONE, ZMMUL, M} m_ext_e;         // ZMMUL is multiply only
  typedef enum logic [1:0] {PRIV_U = 2'b00, PRIV_M = 2'b11} priv_lvl_e;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_LOAD     = 7'h03;
  localparam logic [6:0] OPCODE_MISC_MEM = 7'h0f;
  localparam logic [6:0] OPCODE_OP_IMM   = 7'h13;
  localparam logic [6:0] OPCODE_AUIPC    = 7'h17;
  localparam logic [6:0] OPCODE_STORE    = 7'h23;
  localparam logic [6:0] OPCODE_OP       = 7'h33;
  localparam logic [6:0] OPCODE_LUI      = 7'h37;
  localparam logic [6:0] OPCODE_BRANCH   = 7'h63;
  localparam logic [6:0] OPCODE_JALR     = 7'h67;
  localparam logic [6:0] OPCODE_JAL      = 7'h6f;
  localparam logic [6:0] OPCODE_SYSTEM   = 7'h73;

  ////////////////////////////////////////
  // Operation encodings
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_opcode_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} alu_op_a_mux_e;
  typedef enum logic       {OP_B_REG, OP_B_IMM} alu_op_b_mux_e;
  typedef enum logic [2:0] {IMMB_I, IMMB_S, IMMB_B, IMMB_U, IMMB_J, IMMB_FOUR} imm_b_mux_e;
  typedef enum logic       {MUL_M, MUL_H} mul_opcode_e;        // Low word / high word
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_opcode_e;

  ////////////////////////////////////////
  // Pipe payloads
  ////////////////////////////////////////
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    priv_lvl_e   priv_lvl;
    logic        illegal_c;                                   // Bad compressed encoding
    logic        bus_err;                                     // Fetch bus error
  } fetch_t;

  typedef struct packed {
    logic          illegal_insn;                              // Must stay MSB
    logic          alu_en;
    logic          alu_bch;                                   // Branch compare
    logic          alu_jmp;                                   // JAL or JALR, ALU forms link
    logic          alu_jmpr;                                  // JALR only
    alu_opcode_e   alu_operator;
    alu_op_a_mux_e alu_op_a_mux_sel;
    alu_op_b_mux_e alu_op_b_mux_sel;
    imm_b_mux_e    imm_b_mux_sel;
    logic          mul_en;
    mul_opcode_e   mul_operator;
    logic [1:0]    mul_signed_mode;                           // {rs2 signed, rs1 signed}
    logic          div_en;
    div_opcode_e   div_operator;
    logic          lsu_en;
    logic          lsu_we;
    logic [1:0]    lsu_size;                                  // 00 byte, 01 half, 10 word
    logic          lsu_sext;
    logic [1:0]    rf_re;                                     // [0] rs1, [1] rs2
    logic          rf_we;
    logic          sys_en;
    logic          sys_ecall;
    logic          sys_ebrk;
    logic          sys_mret;
    logic          sys_wfi;
    logic          sys_fence;
    logic          sys_fencei;
  } decoder_ctrl_t;

  // Only illegal_insn set, all other fields zero
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN =
    decoder_ctrl_t'({1'b1, {($bits(decoder_ctrl_t) - 1){1'b0}}});

  typedef struct packed {
    decoder_ctrl_t ctrl;
    logic [31:0]   pc;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    logic [4:0]    rd;
  } id_ex_t;

endpackage

`default_nettype wire

/* rtl/rvdec_i_decoder.sv */
/*
 * RV32I base decoder, combinational
 * CSR instructions are not supported and decode as illegal
 * MRET is legal only in machine mode
 */
`timescale 1ns/10ps
`default_nettype none

module rvdec_i_decoder (
  input  logic [31:0]              instr_i,
  input  rvdec_pkg::priv_lvl_e     priv_lvl_i,
  output rvdec_pkg::decoder_ctrl_t ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Shared funct3 map of OP and OP-IMM, alt selects SUB / SRA
  function automatic rvdec_pkg::alu_opcode_e alu_op(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? rvdec_pkg::ALU_SUB : rvdec_pkg::ALU_ADD;
      3'b001:  return rvdec_pkg::ALU_SLL;
      3'b010:  return rvdec_pkg::ALU_SLT;
      3'b011:  return rvdec_pkg::ALU_SLTU;
      3'b100:  return rvdec_pkg::ALU_XOR;
      3'b101:  return alt ? rvdec_pkg::ALU_SRA : rvdec_pkg::ALU_SRL;
      3'b110:  return rvdec_pkg::ALU_OR;
      default: return rvdec_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    // Legal word with every field cleared: REG/REG operands, imm I, ADD
    ctrl_o              = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
    ctrl_o.illegal_insn = 1'b0;

    case (opcode)
      rvdec_pkg::OPCODE_LUI, rvdec_pkg::OPCODE_AUIPC: begin
        ctrl_o.alu_en           = 1'b1;
        ctrl_o.alu_op_a_mux_sel = (opcode == rvdec_pkg::OPCODE_LUI) ? rvdec_pkg::OP_A_ZERO :
                                                                     rvdec_pkg::OP_A_PC;
        ctrl_o.alu_op_b_mux_sel = rvdec_pkg::OP_B_IMM;
        ctrl_o.imm_b_mux_sel    = rvdec_pkg::IMMB_U;
        ctrl_o.rf_we            = 1'b1;
      end

      rvdec_pkg::OPCODE_JAL, rvdec_pkg::OPCODE_JALR: begin
        ctrl_o.alu_en           = 1'b1;
        ctrl_o.alu_jmp          = 1'b1;
        ctrl_o.alu_jmpr         = (opcode == rvdec_pkg::OPCODE_JALR);
        ctrl_o.alu_op_a_mux_sel = rvdec_pkg::OP_A_PC;     // Link address PC + 4
        ctrl_o.alu_op_b_mux_sel = rvdec_pkg::OP_B_IMM;
        ctrl_o.imm_b_mux_sel    = rvdec_pkg::IMMB_FOUR;
        ctrl_o.rf_re[0]         = ctrl_o.alu_jmpr;        // JALR base register
        ctrl_o.rf_we            = 1'b1;
        if (ctrl_o.alu_jmpr && (funct3 != 3'b000)) begin
          ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      rvdec_pkg::OPCODE_BRANCH: begin
        ctrl_o.alu_en        = 1'b1;
        ctrl_o.alu_bch       = 1'b1;
        ctrl_o.imm_b_mux_sel = rvdec_pkg::IMMB_B;         // Target offset, compare uses rs2
        ctrl_o.rf_re         = 2'b11;
        case (funct3)
          3'b000:  ctrl_o.alu_operator = rvdec_pkg::ALU_EQ;
          3'b001:  ctrl_o.alu_operator = rvdec_pkg::ALU_NE;
          3'b100:  ctrl_o.alu_operator = rvdec_pkg::ALU_LT;
          3'b101:  ctrl_o.alu_operator = rvdec_pkg::ALU_GE;
          3'b110:  ctrl_o.alu_operator = rvdec_pkg::ALU_LTU;
          3'b111:  ctrl_o.alu_operator = rvdec_pkg::ALU_GEU;
          default: ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
        endcase
      end

      rvdec_pkg::OPCODE_LOAD: begin
        ctrl_o.lsu_en           = 1'b1;
        ctrl_o.lsu_size         = funct3[1:0];
        ctrl_o.lsu_sext         = !funct3[2];             // LBU / LHU zero extend
        ctrl_o.alu_op_b_mux_sel = rvdec_pkg::OP_B_IMM;
        ctrl_o.rf_re[0]         = 1'b1;
        ctrl_o.rf_we            = 1'b1;
        if ((funct3[1:0] == 2'b11) || (funct3 == 3'b110)) begin
          ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      rvdec_pkg::OPCODE_STORE: begin
        ctrl_o.lsu_en           = 1'b1;
        ctrl_o.lsu_we           = 1'b1;
        ctrl_o.lsu_size         = funct3[1:0];
        ctrl_o.alu_op_b_mux_sel = rvdec_pkg::OP_B_IMM;
        ctrl_o.imm_b_mux_sel    = rvdec_pkg::IMMB_S;
        ctrl_o.rf_re            = 2'b11;
        if (funct3[2] || (funct3[1:0] == 2'b11)) begin
          ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      rvdec_pkg::OPCODE_OP_IMM: begin
        ctrl_o.alu_en           = 1'b1;
        ctrl_o.alu_operator     = alu_op(funct3, (funct3 == 3'b101) && instr_i[30]);
        ctrl_o.alu_op_b_mux_sel = rvdec_pkg::OP_B_IMM;
        ctrl_o.rf_re[0]         = 1'b1;
        ctrl_o.rf_we            = 1'b1;
        // Shift amounts only take 5 bits, upper funct7 must be clean
        if (((funct3 == 3'b001) && (funct7 != 7'b0)) ||
            ((funct3 == 3'b101) && (funct7 != 7'b0) && (funct7 != 7'b0100000))) begin
          ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      rvdec_pkg::OPCODE_OP: begin
        ctrl_o.alu_en       = 1'b1;
        ctrl_o.alu_operator = alu_op(funct3, instr_i[30]);
        ctrl_o.rf_re        = 2'b11;
        ctrl_o.rf_we        = 1'b1;
        // funct7 = 1 belongs to the M decoder
        if (!((funct7 == 7'b0) ||
              ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101))))) begin
          ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
        end
      end

      rvdec_pkg::OPCODE_MISC_MEM: begin
        ctrl_o.sys_en = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.sys_fence  = 1'b1;
          3'b001:  ctrl_o.sys_fencei = 1'b1;
          default: ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
        endcase
      end

      rvdec_pkg::OPCODE_SYSTEM: begin
        ctrl_o.sys_en = 1'b1;
        if ((funct3 != 3'b000) || (instr_i[19:15] != 5'd0) || (instr_i[11:7] != 5'd0)) begin
          ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;   // CSR space and malformed
        end else begin
          case (instr_i[31:20])
            12'h000: ctrl_o.sys_ecall = 1'b1;
            12'h001: ctrl_o.sys_ebrk  = 1'b1;
            12'h105: ctrl_o.sys_wfi   = 1'b1;
            12'h302: begin
              ctrl_o.sys_mret = 1'b1;
              if (priv_lvl_i != rvdec_pkg::PRIV_M) begin
                ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
              end
            end
            default: ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
          endcase
        end
      end

      default: ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
    endcase
  end

  // Every illegal path above must collapse to a word with no side effects
  a_illegal_no_en: assert final (!ctrl_o.illegal_insn ||
      !(ctrl_o.alu_en || ctrl_o.lsu_en || ctrl_o.sys_en || ctrl_o.rf_we))
    else $error("I decoder flags illegal with an enable set");

endmodule

`default_nettype wire

/* rtl/rvdec_m_decoder.sv */
/*
 * RV32M decoder, combinational
 * ZMMUL decodes the multiply group only, division is then illegal
 */
`timescale 1ns/10ps
`default_nettype none

module rvdec_m_decoder #(
  parameter rvdec_pkg::m_ext_e M_EXT = rvdec_pkg::M
) (
  input  logic [31:0]              instr_i,
  output rvdec_pkg::decoder_ctrl_t ctrl_o
);

  logic is_muldiv;
  logic is_mul;
  logic is_div;

  assign is_muldiv = (instr_i[6:0] == rvdec_pkg::OPCODE_OP) && (instr_i[31:25] == 7'b0000001);
  assign is_mul    = is_muldiv && !instr_i[14] && (M_EXT != rvdec_pkg::M_NONE);
  assign is_div    = is_muldiv &&  instr_i[14] && (M_EXT == rvdec_pkg::M);

  always_comb begin
    ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (is_mul || is_div) begin
      ctrl_o.illegal_insn = 1'b0;
      ctrl_o.rf_re        = 2'b11;                        // Always rs1 and rs2
      ctrl_o.rf_we        = 1'b1;
      if (is_mul) begin
        ctrl_o.mul_en       = 1'b1;
        ctrl_o.mul_operator = (instr_i[13:12] == 2'b00) ? rvdec_pkg::MUL_M : rvdec_pkg::MUL_H;
        case (instr_i[13:12])
          2'b01:   ctrl_o.mul_signed_mode = 2'b11;        // MULH
          2'b10:   ctrl_o.mul_signed_mode = 2'b01;        // MULHSU, rs1 signed only
          default: ctrl_o.mul_signed_mode = 2'b00;        // MUL, MULHU
        endcase
      end else begin
        ctrl_o.div_en       = 1'b1;
        // funct3[1:0] order matches DIV, DIVU, REM, REMU
        ctrl_o.div_operator = rvdec_pkg::div_opcode_e'(instr_i[13:12]);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rvdec_pipe_slot.sv */
/*
 * One-deep pipeline register for any packed payload
 * No back-pressure, a strobe is always taken
 * Payload is held between strobes
 */
`timescale 1ns/10ps
`default_nettype none

module rvdec_pipe_slot #(
  parameter type T_PAYLOAD = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  T_PAYLOAD data_i,
  output logic     valid_o,
  output T_PAYLOAD data_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
      data_o  <= '0;
    end else begin
      valid_o <= valid_i;                 // Strobe out one cycle later
      if (valid_i) begin
        data_o <= data_i;                 // Load only on a strobe
      end
    end
  end

  a_data_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 valid_o |-> !$isunknown(data_o))
    else $error("Pipe slot presents X payload with valid");

endmodule

`default_nettype wire

/* rtl/rvdec_decoder.sv */
/*
 * Decoder top: I and M sub-decoders, RV32E address check and merge
 * Combinational, the fetch-error suppression is applied last
 * Register addresses are taken straight from the 32-bit encoding
 */
`timescale 1ns/10ps
`default_nettype none

module rvdec_decoder #(
  parameter rvdec_pkg::rv32_e  RV32  = rvdec_pkg::RV32I,
  parameter rvdec_pkg::m_ext_e M_EXT = rvdec_pkg::M
) (
  input  rvdec_pkg::fetch_t        instr_i,
  output rvdec_pkg::decoder_ctrl_t ctrl_o
);

  rvdec_pkg::decoder_ctrl_t dec_i_ctrl_raw;   // Straight from sub-decoders
  rvdec_pkg::decoder_ctrl_t dec_m_ctrl_raw;
  rvdec_pkg::decoder_ctrl_t dec_i_ctrl;       // After RV32E / compressed checks
  rvdec_pkg::decoder_ctrl_t dec_m_ctrl;
  rvdec_pkg::decoder_ctrl_t dec_mux;

  // x16..x31 do not exist in RV32E, bit 4 of rs1 / rs2 / rd
  function automatic rvdec_pkg::decoder_ctrl_t apply_checks(rvdec_pkg::decoder_ctrl_t ctrl,
                                                            logic [31:0] instr,
                                                            logic illegal_c);
    logic addr_bad;
    addr_bad = (ctrl.rf_re[0] && instr[19]) ||
               (ctrl.rf_re[1] && instr[24]) ||
               (ctrl.rf_we    && instr[11]);
    if (((RV32 == rvdec_pkg::RV32E) && addr_bad) || illegal_c) begin
      return rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
    end
    return ctrl;
  endfunction

  ////////////////////////////////////////
  // Sub-decoders
  ////////////////////////////////////////
  rvdec_i_decoder i_i_decoder (
    .instr_i    (instr_i.instr),
    .priv_lvl_i (instr_i.priv_lvl),
    .ctrl_o     (dec_i_ctrl_raw)
  );

  if (M_EXT != rvdec_pkg::M_NONE) begin : gen_m_decoder
    rvdec_m_decoder #(
      .M_EXT (M_EXT)
    ) i_m_decoder (
      .instr_i (instr_i.instr),
      .ctrl_o  (dec_m_ctrl_raw)
    );
  end else begin : gen_no_m_decoder
    assign dec_m_ctrl_raw = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;  // Never matches
  end

  assign dec_i_ctrl = apply_checks(dec_i_ctrl_raw, instr_i.instr, instr_i.illegal_c);
  assign dec_m_ctrl = apply_checks(dec_m_ctrl_raw, instr_i.instr, instr_i.illegal_c);

  ////////////////////////////////////////
  // Merge, M before I
  ////////////////////////////////////////
  always_comb begin
    if (!dec_m_ctrl.illegal_insn) begin
      dec_mux = dec_m_ctrl;
    end else if (!dec_i_ctrl.illegal_insn) begin
      dec_mux = dec_i_ctrl;
    end else begin
      dec_mux = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;         // No decoder claimed it
    end
  end

  always_comb begin
    ctrl_o                 = dec_mux;
    ctrl_o.alu_bch         = dec_i_ctrl.alu_bch;   // Flow control lives in the I decoder
    ctrl_o.alu_jmp         = dec_i_ctrl.alu_jmp;
    ctrl_o.alu_jmpr        = dec_i_ctrl.alu_jmpr;
    ctrl_o.sys_en          = dec_i_ctrl.sys_en;
    ctrl_o.sys_ecall       = dec_i_ctrl.sys_ecall;
    ctrl_o.sys_ebrk        = dec_i_ctrl.sys_ebrk;
    ctrl_o.sys_mret        = dec_i_ctrl.sys_mret;
    ctrl_o.sys_wfi         = dec_i_ctrl.sys_wfi;
    ctrl_o.sys_fence       = dec_i_ctrl.sys_fence;
    ctrl_o.sys_fencei      = dec_i_ctrl.sys_fencei;
    ctrl_o.mul_en          = dec_m_ctrl.mul_en;    // Mul / div only from the M decoder
    ctrl_o.mul_operator    = dec_m_ctrl.mul_operator;
    ctrl_o.mul_signed_mode = dec_m_ctrl.mul_signed_mode;
    ctrl_o.div_en          = dec_m_ctrl.div_en;
    ctrl_o.div_operator    = dec_m_ctrl.div_operator;

    // Fetch error, the word has no effect and raises no illegal trap
    if (instr_i.bus_err) begin
      ctrl_o.alu_en       = 1'b0;
      ctrl_o.mul_en       = 1'b0;
      ctrl_o.div_en       = 1'b0;
      ctrl_o.lsu_en       = 1'b0;
      ctrl_o.sys_en       = 1'b0;
      ctrl_o.rf_we        = 1'b0;
      ctrl_o.illegal_insn = 1'b0;
    end
  end

  // Encodings of I and M must stay disjoint for the fixed priority to hold
  a_single_match: assert final (dec_m_ctrl.illegal_insn || dec_i_ctrl.illegal_insn)
    else $error("I and M decoders both claim the instruction");

endmodule

`default_nettype wire

/* rtl/rvdec_id_stage.sv */
/*
 * Instruction decode stage, IF/ID slot -> decoder -> ID/EX slot
 * Fixed latency of two cycles from fetch_valid_i to id_ex_valid_o
 * Every strobe is accepted, fetch may strobe each cycle
 */
`timescale 1ns/10ps
`default_nettype none

module rvdec_id_stage #(
  parameter rvdec_pkg::rv32_e  RV32  = rvdec_pkg::RV32I,
  parameter rvdec_pkg::m_ext_e M_EXT = rvdec_pkg::M
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              fetch_valid_i,
  input  rvdec_pkg::fetch_t fetch_i,
  output logic              id_ex_valid_o,
  output rvdec_pkg::id_ex_t id_ex_o
);

  logic                     if_id_valid;
  rvdec_pkg::fetch_t        if_id;
  rvdec_pkg::decoder_ctrl_t dec_ctrl;
  rvdec_pkg::id_ex_t        id_ex;

  // IF/ID
  rvdec_pipe_slot #(
    .T_PAYLOAD (rvdec_pkg::fetch_t)
  ) i_if_id_slot (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (fetch_valid_i),
    .data_i   (fetch_i),
    .valid_o  (if_id_valid),
    .data_o   (if_id)
  );

  rvdec_decoder #(
    .RV32  (RV32),
    .M_EXT (M_EXT)
  ) i_decoder (
    .instr_i (if_id),
    .ctrl_o  (dec_ctrl)
  );

  // Register addresses ride along for the register file read in EX
  assign id_ex = '{ctrl: dec_ctrl,
                   pc:   if_id.pc,
                   rs1:  if_id.instr[19:15],
                   rs2:  if_id.instr[24:20],
                   rd:   if_id.instr[11:7]};

  // ID/EX
  rvdec_pipe_slot #(
    .T_PAYLOAD (rvdec_pkg::id_ex_t)
  ) i_id_ex_slot (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (if_id_valid),
    .data_i   (id_ex),
    .valid_o  (id_ex_valid_o),
    .data_o   (id_ex_o)
  );

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
/*
 * Testbench clock and reset source
 * Reset is released on a falling edge, clear of the DUT's sampling edge
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;                  // Asserted from time zero
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* tests/tb_rvdec_id_stage.sv */
/*
 * Testbench of the decode stage, DUT built as RV32E with the full M extension
 * Expected control words are written out per row from the decode rules
 * The table runs twice, first with random idle gaps, then back to back
 */
`timescale 1ns/10ps
`default_nettype none

module tb_rvdec_id_stage;

  localparam int RST_CYCLES = 10;
  localparam int MAX_GAP    = 2;      // Idle cycles between strobes, gapped pass
  localparam int MAX_ROWS   = 32;

  logic              clk;
  logic              arst_n;
  logic              fetch_valid;
  rvdec_pkg::fetch_t fetch;
  logic              id_ex_valid;
  rvdec_pkg::id_ex_t id_ex;

  // Stimulus table
  string                    row_name [MAX_ROWS];
  rvdec_pkg::fetch_t        row_fetch[MAX_ROWS];
  rvdec_pkg::decoder_ctrl_t row_ctrl [MAX_ROWS];
  int                       num_rows = 0;

  // Scoreboard, one entry per strobe in flight
  rvdec_pkg::id_ex_t exp_q[$];
  string             name_q[$];
  int                cyc_q[$];
  rvdec_pkg::id_ex_t exp_id_ex;
  string             exp_name;
  int                exp_cyc;
  rvdec_pkg::id_ex_t last_id_ex;      // Payload of the most recent output strobe

  int     cycle_cnt      = 0;         // Rising edges since time zero
  int     out_cnt        = 0;
  int     timeout_cycles = 0;         // Zero until the table is built
  int     mismatch_cnt   = 0;
  int     fail_cnt       = 0;
  integer seed;

  tb_clk_gen #(
    .PERIOD_NS  (8),
    .RST_CYCLES (RST_CYCLES)
  ) i_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  rvdec_id_stage #(
    .RV32  (rvdec_pkg::RV32E),
    .M_EXT (rvdec_pkg::M)
  ) i_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .fetch_valid_i (fetch_valid),
    .fetch_i       (fetch),
    .id_ex_valid_o (id_ex_valid),
    .id_ex_o       (id_ex)
  );

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_id_ex(input string name, input rvdec_pkg::id_ex_t exp,
                             input rvdec_pkg::id_ex_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // Expected word builders
  ////////////////////////////////////////
  // ALU and flow control, everything not named stays zero
  function automatic rvdec_pkg::decoder_ctrl_t alu_word(rvdec_pkg::alu_opcode_e op,
                                                        rvdec_pkg::alu_op_a_mux_e a_sel,
                                                        rvdec_pkg::alu_op_b_mux_e b_sel,
                                                        rvdec_pkg::imm_b_mux_e imm_sel,
                                                        logic [1:0] re, logic we);
    rvdec_pkg::decoder_ctrl_t c;
    c                  = '0;
    c.alu_en           = 1'b1;
    c.alu_operator     = op;
    c.alu_op_a_mux_sel = a_sel;
    c.alu_op_b_mux_sel = b_sel;
    c.imm_b_mux_sel    = imm_sel;
    c.rf_re            = re;
    c.rf_we            = we;
    return c;
  endfunction

  // Loads write rd, stores do not; address is always rs1 + imm
  function automatic rvdec_pkg::decoder_ctrl_t lsu_word(logic we, logic [1:0] size,
                                                        logic sext,
                                                        rvdec_pkg::imm_b_mux_e imm_sel,
                                                        logic [1:0] re);
    rvdec_pkg::decoder_ctrl_t c;
    c                  = '0;
    c.lsu_en           = 1'b1;
    c.lsu_we           = we;
    c.lsu_size         = size;
    c.lsu_sext         = sext;
    c.alu_op_b_mux_sel = rvdec_pkg::OP_B_IMM;
    c.imm_b_mux_sel    = imm_sel;
    c.rf_re            = re;
    c.rf_we            = !we;
    return c;
  endfunction

  task automatic add_row(input string name, input logic [31:0] instr, input logic priv_m,
                         input logic illegal_c, input logic bus_err,
                         input rvdec_pkg::decoder_ctrl_t ctrl);
    row_name[num_rows]            = name;
    row_fetch[num_rows].instr     = instr;
    row_fetch[num_rows].pc        = 32'h0000_1000 + 32'(num_rows * 4);
    row_fetch[num_rows].priv_lvl  = priv_m ? rvdec_pkg::PRIV_M : rvdec_pkg::PRIV_U;
    row_fetch[num_rows].illegal_c = illegal_c;
    row_fetch[num_rows].bus_err   = bus_err;
    row_ctrl[num_rows]            = ctrl;
    num_rows++;
  endtask

  task automatic build_table();
    rvdec_pkg::decoder_ctrl_t c;
    // Base ISA
    c = alu_word(rvdec_pkg::ALU_ADD, rvdec_pkg::OP_A_REG, rvdec_pkg::OP_B_REG,
                 rvdec_pkg::IMMB_I, 2'b11, 1'b1);
    add_row("add_x3_x1_x2", 32'h002081b3, 1'b1, 1'b0, 1'b0, c);
    c = alu_word(rvdec_pkg::ALU_ADD, rvdec_pkg::OP_A_REG, rvdec_pkg::OP_B_IMM,
                 rvdec_pkg::IMMB_I, 2'b01, 1'b1);
    add_row("addi_x5_x6_12", 32'h00c30293, 1'b1, 1'b0, 1'b0, c);
    c = lsu_word(1'b0, 2'b10, 1'b1, rvdec_pkg::IMMB_I, 2'b01);      // Word, sign extended
    add_row("lw_x7_8_x2", 32'h00812383, 1'b1, 1'b0, 1'b0, c);
    c = lsu_word(1'b1, 2'b00, 1'b0, rvdec_pkg::IMMB_S, 2'b11);
    add_row("sb_x4_3_x9", 32'h004481a3, 1'b1, 1'b0, 1'b0, c);
    c = alu_word(rvdec_pkg::ALU_EQ, rvdec_pkg::OP_A_REG, rvdec_pkg::OP_B_REG,
                 rvdec_pkg::IMMB_B, 2'b11, 1'b0);
    c.alu_bch = 1'b1;
    add_row("beq_x1_x2_16", 32'h00208863, 1'b1, 1'b0, 1'b0, c);  // rd field x16, unused
    c = alu_word(rvdec_pkg::ALU_ADD, rvdec_pkg::OP_A_PC, rvdec_pkg::OP_B_IMM,
                 rvdec_pkg::IMMB_FOUR, 2'b00, 1'b1);              // Link is PC + 4
    c.alu_jmp = 1'b1;
    add_row("jal_x1_8", 32'h008000ef, 1'b1, 1'b0, 1'b0, c);
    c = alu_word(rvdec_pkg::ALU_ADD, rvdec_pkg::OP_A_ZERO, rvdec_pkg::OP_B_IMM,
                 rvdec_pkg::IMMB_U, 2'b00, 1'b1);
    add_row("lui_x10", 32'h12345537, 1'b1, 1'b0, 1'b0, c);
    // M extension, ALU stays idle
    c          = '0;
    c.mul_en   = 1'b1;
    c.rf_re    = 2'b11;
    c.rf_we    = 1'b1;
    add_row("mul_x3_x1_x2", 32'h022081b3, 1'b1, 1'b0, 1'b0, c);
    c.mul_operator    = rvdec_pkg::MUL_H;
    c.mul_signed_mode = 2'b01;                                    // rs1 signed only
    add_row("mulhsu_x4_x5_x6", 32'h0262a233, 1'b1, 1'b0, 1'b0, c);
    c              = '0;
    c.div_en       = 1'b1;
    c.div_operator = rvdec_pkg::DIV_DIVU;
    c.rf_re        = 2'b11;
    c.rf_we        = 1'b1;
    add_row("divu_x7_x8_x9", 32'h029453b3, 1'b1, 1'b0, 1'b0, c);
    // Illegal, flag only
    c              = '0;
    c.illegal_insn = 1'b1;
    add_row("unknown_opcode", 32'h0000007f, 1'b1, 1'b0, 1'b0, c);
    add_row("add_rd_x17_rv32e", 32'h002088b3, 1'b1, 1'b0, 1'b0, c);
    add_row("add_illegal_c", 32'h002081b3, 1'b1, 1'b1, 1'b0, c);
    add_row("mret_priv_u", 32'h30200073, 1'b0, 1'b0, 1'b0, c);
    c          = '0;
    c.sys_en   = 1'b1;
    c.sys_mret = 1'b1;
    add_row("mret_priv_m", 32'h30200073, 1'b1, 1'b0, 1'b0, c);
    // Fetch error, read ports remain but nothing is enabled or flagged
    c       = '0;
    c.rf_re = 2'b11;
    add_row("add_bus_err", 32'h002081b3, 1'b1, 1'b0, 1'b1, c);
    c = '0;
    add_row("illegal_bus_err", 32'h0000007f, 1'b1, 1'b0, 1'b1, c);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic run_pass(input string pass_name, input logic with_gaps);
    int                gap;
    logic [95:0]       noise;
    rvdec_pkg::id_ex_t entry;
    out_cnt = 0;
    for (int i = 0; i < num_rows; i++) begin
      gap = with_gaps ? int'($unsigned($random(seed)) % (MAX_GAP + 1)) : 0;
      repeat (gap) begin
        @(posedge clk);
        #1;
        noise       = {$random(seed), $random(seed), $random(seed)};
        fetch_valid = 1'b0;
        fetch       = noise[67:0];    // Junk without a strobe, slot must hold
      end
      @(posedge clk);
      #1;
      fetch_valid = 1'b1;
      fetch       = row_fetch[i];
      entry.ctrl  = row_ctrl[i];
      entry.pc    = row_fetch[i].pc;
      entry.rs1   = row_fetch[i].instr[19:15];
      entry.rs2   = row_fetch[i].instr[24:20];
      entry.rd    = row_fetch[i].instr[11:7];
      exp_q.push_back(entry);
      name_q.push_back({pass_name, "/", row_name[i]});
      cyc_q.push_back(cycle_cnt);
    end
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
    while (out_cnt < num_rows) @(negedge clk);
    repeat (4) @(negedge clk);        // Catch any extra strobe
    check_count({pass_name, "/output_count"}, num_rows, out_cnt);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////
  // Output monitor, mid-cycle sampling
  ////////////////////////////////////////
  always @(negedge clk) begin
    if (!arst_n) begin
      if (id_ex_valid !== 1'b0) begin
        $display("ERROR: id_ex_valid_o is not low during reset at cycle %0d", cycle_cnt);
        fail_cnt++;
      end
      check_id_ex("reset_payload", '0, id_ex);
      last_id_ex = '0;
    end else if (id_ex_valid === 1'b1) begin
      out_cnt++;
      last_id_ex = id_ex;
      if (exp_q.size() == 0) begin
        $display("ERROR: output strobe at cycle %0d with nothing in flight", cycle_cnt);
        fail_cnt++;
      end else begin
        exp_id_ex = exp_q.pop_front();
        exp_name  = name_q.pop_front();
        exp_cyc   = cyc_q.pop_front();
        check_id_ex(exp_name, exp_id_ex, id_ex);
        if ((cycle_cnt - exp_cyc) != 2) begin                   // Fixed two-cycle latency
          $display("ERROR: %s came out %0d cycles after its strobe instead of 2",
                   exp_name, cycle_cnt - exp_cyc);
          fail_cnt++;
        end
      end
    end else begin
      check_id_ex("hold_without_strobe", last_id_ex, id_ex);    // Quiet cycle keeps payload
    end
  end

  initial begin : main
    seed        = 32'h67af2c06;
    fetch_valid = 1'b0;
    fetch       = '0;
    build_table();
    // Reset, both passes with worst-case gaps, drain margin
    timeout_cycles = RST_CYCLES + num_rows * (MAX_GAP + 2) + 20;
    @(posedge arst_n);
    run_pass("gapped", 1'b1);
    run_pass("back_to_back", 1'b0);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if ((mismatch_cnt + fail_cnt) == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    wait (timeout_cycles > 0);
    wait (cycle_cnt >= timeout_cycles);
    $display("ERROR: run did not complete within %0d cycles, %0d outputs still missing",
             timeout_cycles, exp_q.size());
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/rvdec_pkg.sv
rtl/rvdec_i_decoder.sv
rtl/rvdec_m_decoder.sv
rtl/rvdec_pipe_slot.sv
rtl/rvdec_decoder.sv
rtl/rvdec_id_stage.sv
tests/tb_clk_gen.sv
tests/tb_rvdec_id_stage.sv

/* Bender.yml */
package:
  name: rvdec_id_stage

sources:
  # Design, in compile order
  - rtl/rvdec_pkg.sv
  - rtl/rvdec_i_decoder.sv
  - rtl/rvdec_m_decoder.sv
  - rtl/rvdec_pipe_slot.sv
  - rtl/rvdec_decoder.sv
  - rtl/rvdec_id_stage.sv

  # Testbench
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_rvdec_id_stage.sv
